//--- hw/lc3b_types.sv
package lc3b_types;

// data and address words are both 16 bits wide
typedef logic [15:0] lc3b_word;

// architectural register index
typedef logic [2:0] lc3b_reg;

// condition flags, ordered n z p
typedef logic [2:0] lc3b_nzp;

// instruction opcodes, bits 15:12 of the instruction word
// any value not listed here executes as a no-op
typedef enum logic [3:0] {
    op_br  = 4'd0,
    op_add = 4'd1,
    op_and = 4'd5,
    op_ldr = 4'd6,
    op_str = 4'd7,
    op_not = 4'd9,
    op_lea = 4'd14
} lc3b_opcode;

// operations performed by the execute stage
// alu_pass forwards the computed address
typedef enum logic [1:0] {
    alu_add,
    alu_and,
    alu_not,
    alu_pass
} lc3b_alu_op;

// writeback source
typedef enum logic {
    wb_alu,
    wb_mdr
} lc3b_wb_sel;

// number of architectural registers
localparam int reg_count = 8;

// flags come out of reset holding z
localparam lc3b_nzp cc_reset = 3'b010;

// memories index words by address bits 8 to 1
localparam int mem_index_bits = 8;

endpackage : lc3b_types

//--- hw/stage_if.sv
module stage_if (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 if_hold,
    input  logic                 br_taken,
    input  lc3b_types::lc3b_word br_target,
    output lc3b_types::lc3b_word imem_addr,
    input  lc3b_types::lc3b_word imem_rdata,
    output logic                 if_id_valid,
    output lc3b_types::lc3b_word if_id_ir,
    output lc3b_types::lc3b_word if_id_pc
);

import lc3b_types::*;

lc3b_word pc;
lc3b_word pc_plus2;
logic keep_entry;

assign imem_addr = pc;
assign pc_plus2 = pc + 16'd2;

// under a hold, a valid non-branch word in IF/ID can only be an
// interlocked instruction, so decode keeps it; a branch still moves on
assign keep_entry = if_hold && if_id_valid && (lc3b_opcode'(if_id_ir[15:12]) != op_br);

// branch target wins over the fetch hold
always_ff @(posedge clk) begin
    if (reset) begin
        pc <= 16'h0000;
    end else if (br_taken) begin
        pc <= br_target;
    end else if (!if_hold) begin
        pc <= pc_plus2;
    end
end

// a bubble enters IF/ID while fetch is held
always_ff @(posedge clk) begin
    if (reset) begin
        if_id_valid <= 1'b0;
    end else if (!keep_entry) begin
        if_id_valid <= !if_hold;
    end
end

always_ff @(posedge clk) begin
    if (!if_hold) begin
        if_id_ir <= imem_rdata;
        if_id_pc <= pc_plus2;
    end
end

endmodule : stage_if

//--- hw/stage_id.sv
module stage_id (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   id_hold,
    input  logic                   id_bubble,
    input  logic                   if_id_valid,
    input  lc3b_types::lc3b_word   if_id_ir,
    input  lc3b_types::lc3b_word   if_id_pc,
    input  logic                   wb_load,
    input  lc3b_types::lc3b_reg    wb_dest,
    input  lc3b_types::lc3b_word   wb_data,
    output logic                   id_ex_valid,
    output lc3b_types::lc3b_opcode id_ex_opcode,
    output lc3b_types::lc3b_alu_op id_ex_alu_op,
    output lc3b_types::lc3b_wb_sel id_ex_wb_sel,
    output logic                   id_ex_load_reg,
    output lc3b_types::lc3b_reg    id_ex_dest,
    output logic                   id_ex_sets_cc,
    output logic                   id_ex_mem_read,
    output logic                   id_ex_mem_write,
    output lc3b_types::lc3b_word   id_ex_sr1,
    output lc3b_types::lc3b_word   id_ex_sr2,
    output lc3b_types::lc3b_word   id_ex_imm,
    output lc3b_types::lc3b_word   id_ex_pc,
    output lc3b_types::lc3b_nzp    id_ex_nzp
);

import lc3b_types::*;

lc3b_word regs [reg_count];
lc3b_opcode opcode;
lc3b_reg sr1_idx;
lc3b_reg sr2_idx;
lc3b_word sr1_val;
lc3b_word sr2_val;
lc3b_word operand_b;
lc3b_word imm;
lc3b_alu_op alu_op;
lc3b_wb_sel wb_sel;
logic load_reg;
logic sets_cc;
logic mem_read;
logic mem_write;

assign opcode = lc3b_opcode'(if_id_ir[15:12]);
assign sr1_idx = if_id_ir[8:6];
// a store reads its data register from the SR field
assign sr2_idx = (opcode == op_str) ? if_id_ir[11:9] : if_id_ir[2:0];

// write-through so the writeback cycle needs no interlock
assign sr1_val = (wb_load && (wb_dest == sr1_idx)) ? wb_data : regs[sr1_idx];
assign sr2_val = (wb_load && (wb_dest == sr2_idx)) ? wb_data : regs[sr2_idx];

always_comb begin
    alu_op = alu_pass;
    wb_sel = wb_alu;
    load_reg = 1'b0;
    sets_cc = 1'b0;
    mem_read = 1'b0;
    mem_write = 1'b0;
    operand_b = sr2_val;
    // PCoffset9 unless the opcode says otherwise
    imm = {{7{if_id_ir[8]}}, if_id_ir[8:0]};
    case (opcode)
        op_add, op_and: begin
            alu_op = (opcode == op_add) ? alu_add : alu_and;
            load_reg = 1'b1;
            sets_cc = 1'b1;
            // imm5 form replaces the second register operand
            if (if_id_ir[5]) begin
                operand_b = {{11{if_id_ir[4]}}, if_id_ir[4:0]};
            end
        end
        op_not: begin
            alu_op = alu_not;
            load_reg = 1'b1;
            sets_cc = 1'b1;
        end
        op_ldr: begin
            wb_sel = wb_mdr;
            load_reg = 1'b1;
            sets_cc = 1'b1;
            mem_read = 1'b1;
            imm = {{10{if_id_ir[5]}}, if_id_ir[5:0]};
        end
        op_str: begin
            mem_write = 1'b1;
            imm = {{10{if_id_ir[5]}}, if_id_ir[5:0]};
        end
        op_lea: begin
            load_reg = 1'b1;
        end
        default: begin
            // BR and unsupported opcodes write nothing
            load_reg = 1'b0;
        end
    endcase
end

always_ff @(posedge clk) begin
    if (reset) begin
        for (int i = 0; i < reg_count; i++) begin
            regs[i] <= 16'h0000;
        end
    end else if (wb_load) begin
        regs[wb_dest] <= wb_data;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        id_ex_valid <= 1'b0;
    end else begin
        id_ex_valid <= if_id_valid && !id_bubble;
    end
end

// control fields stay put while decode is held
always_ff @(posedge clk) begin
    if (reset) begin
        id_ex_load_reg <= 1'b0;
        id_ex_sets_cc <= 1'b0;
        id_ex_mem_read <= 1'b0;
        id_ex_mem_write <= 1'b0;
    end else if (!id_hold) begin
        id_ex_load_reg <= load_reg;
        id_ex_sets_cc <= sets_cc;
        id_ex_mem_read <= mem_read;
        id_ex_mem_write <= mem_write;
    end
end

always_ff @(posedge clk) begin
    if (!id_hold) begin
        id_ex_opcode <= opcode;
        id_ex_alu_op <= alu_op;
        id_ex_wb_sel <= wb_sel;
        id_ex_dest <= if_id_ir[11:9];
        id_ex_sr1 <= sr1_val;
        id_ex_sr2 <= operand_b;
        id_ex_imm <= imm;
        id_ex_pc <= if_id_pc;
        id_ex_nzp <= if_id_ir[11:9];
    end
end

endmodule : stage_id

//--- hw/stage_ex.sv
module stage_ex (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   id_ex_valid,
    input  lc3b_types::lc3b_opcode id_ex_opcode,
    input  lc3b_types::lc3b_alu_op id_ex_alu_op,
    input  lc3b_types::lc3b_wb_sel id_ex_wb_sel,
    input  logic                   id_ex_load_reg,
    input  lc3b_types::lc3b_reg    id_ex_dest,
    input  logic                   id_ex_sets_cc,
    input  logic                   id_ex_mem_read,
    input  logic                   id_ex_mem_write,
    input  lc3b_types::lc3b_word   id_ex_sr1,
    input  lc3b_types::lc3b_word   id_ex_sr2,
    input  lc3b_types::lc3b_word   id_ex_imm,
    input  lc3b_types::lc3b_word   id_ex_pc,
    input  lc3b_types::lc3b_nzp    id_ex_nzp,
    output logic                   ex_mem_valid,
    output lc3b_types::lc3b_opcode ex_mem_opcode,
    output lc3b_types::lc3b_wb_sel ex_mem_wb_sel,
    output logic                   ex_mem_load_reg,
    output lc3b_types::lc3b_reg    ex_mem_dest,
    output logic                   ex_mem_sets_cc,
    output logic                   ex_mem_mem_read,
    output logic                   ex_mem_mem_write,
    output lc3b_types::lc3b_word   ex_mem_alu,
    output lc3b_types::lc3b_word   ex_mem_store_data,
    output lc3b_types::lc3b_nzp    ex_mem_nzp
);

import lc3b_types::*;

lc3b_word addr_base;
lc3b_word address;
lc3b_word alu_result;

// loads and stores are register relative, LEA and BR are PC relative
assign addr_base = (id_ex_opcode == op_ldr || id_ex_opcode == op_str) ? id_ex_sr1 : id_ex_pc;
assign address = addr_base + {id_ex_imm[14:0], 1'b0};

always_comb begin
    case (id_ex_alu_op)
        alu_add: alu_result = id_ex_sr1 + id_ex_sr2;
        alu_and: alu_result = id_ex_sr1 & id_ex_sr2;
        alu_not: alu_result = ~id_ex_sr1;
        default: alu_result = address;
    endcase
end

always_ff @(posedge clk) begin
    if (reset) begin
        ex_mem_valid <= 1'b0;
        ex_mem_load_reg <= 1'b0;
        ex_mem_sets_cc <= 1'b0;
        ex_mem_mem_read <= 1'b0;
        ex_mem_mem_write <= 1'b0;
    end else begin
        ex_mem_valid <= id_ex_valid;
        ex_mem_load_reg <= id_ex_load_reg;
        ex_mem_sets_cc <= id_ex_sets_cc;
        ex_mem_mem_read <= id_ex_mem_read;
        ex_mem_mem_write <= id_ex_mem_write;
    end
end

always_ff @(posedge clk) begin
    ex_mem_opcode <= id_ex_opcode;
    ex_mem_wb_sel <= id_ex_wb_sel;
    ex_mem_dest <= id_ex_dest;
    ex_mem_alu <= alu_result;
    ex_mem_store_data <= id_ex_sr2;
    ex_mem_nzp <= id_ex_nzp;
end

endmodule : stage_ex

//--- hw/stage_mem.sv
module stage_mem (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ex_mem_valid,
    input  lc3b_types::lc3b_opcode ex_mem_opcode,
    input  lc3b_types::lc3b_wb_sel ex_mem_wb_sel,
    input  logic                   ex_mem_load_reg,
    input  lc3b_types::lc3b_reg    ex_mem_dest,
    input  logic                   ex_mem_sets_cc,
    input  logic                   ex_mem_mem_read,
    input  logic                   ex_mem_mem_write,
    input  lc3b_types::lc3b_word   ex_mem_alu,
    input  lc3b_types::lc3b_word   ex_mem_store_data,
    input  lc3b_types::lc3b_nzp    ex_mem_nzp,
    output logic                   dmem_read,
    output logic                   dmem_write,
    output lc3b_types::lc3b_word   dmem_addr,
    output lc3b_types::lc3b_word   dmem_wdata,
    input  lc3b_types::lc3b_word   dmem_rdata,
    output logic                   br_taken,
    output lc3b_types::lc3b_word   br_target,
    output logic                   wb_load,
    output lc3b_types::lc3b_reg    wb_dest,
    output lc3b_types::lc3b_word   wb_data
);

import lc3b_types::*;

lc3b_nzp cc;
lc3b_nzp result_nzp;
lc3b_word result;

assign dmem_read = ex_mem_valid && ex_mem_mem_read;
assign dmem_write = ex_mem_valid && ex_mem_mem_write;
assign dmem_addr = ex_mem_alu;
assign dmem_wdata = ex_mem_store_data;

// memory read data is valid in the strobe cycle
assign result = (ex_mem_wb_sel == wb_mdr) ? dmem_rdata : ex_mem_alu;

always_comb begin
    if (result[15]) begin
        result_nzp = 3'b100;
    end else if (result == 16'h0000) begin
        result_nzp = 3'b010;
    end else begin
        result_nzp = 3'b001;
    end
end

// flags already reflect every older instruction when BR gets here
assign br_taken = ex_mem_valid && (ex_mem_opcode == op_br) && |(ex_mem_nzp & cc);
assign br_target = ex_mem_alu;

always_ff @(posedge clk) begin
    if (reset) begin
        cc <= cc_reset;
    end else if (ex_mem_valid && ex_mem_sets_cc) begin
        cc <= result_nzp;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        wb_load <= 1'b0;
    end else begin
        wb_load <= ex_mem_valid && ex_mem_load_reg;
    end
end

always_ff @(posedge clk) begin
    wb_dest <= ex_mem_dest;
    wb_data <= result;
end

endmodule : stage_mem

//--- hw/hazard_controller.sv
module hazard_controller (
    input  logic                   if_id_valid,
    input  lc3b_types::lc3b_word   if_id_ir,
    input  logic                   id_ex_valid,
    input  lc3b_types::lc3b_opcode id_ex_opcode,
    input  logic                   id_ex_load_reg,
    input  lc3b_types::lc3b_reg    id_ex_dest,
    input  logic                   ex_mem_valid,
    input  lc3b_types::lc3b_opcode ex_mem_opcode,
    input  logic                   ex_mem_load_reg,
    input  lc3b_types::lc3b_reg    ex_mem_dest,
    output logic                   if_hold,
    output logic                   id_hold,
    output logic                   id_bubble
);

import lc3b_types::*;

lc3b_opcode opcode;
lc3b_reg sr1_idx;
lc3b_reg sr2_idx;
logic uses_sr1;
logic uses_sr2;
logic branch_in_flight;
logic id_ex_conflict;
logic ex_mem_conflict;

assign opcode = lc3b_opcode'(if_id_ir[15:12]);
assign sr1_idx = if_id_ir[8:6];
assign sr2_idx = (opcode == op_str) ? if_id_ir[11:9] : if_id_ir[2:0];

// which source fields the decoding instruction actually reads
always_comb begin
    uses_sr1 = 1'b0;
    uses_sr2 = 1'b0;
    case (opcode)
        op_add, op_and: begin
            uses_sr1 = 1'b1;
            uses_sr2 = !if_id_ir[5];
        end
        op_not, op_ldr: uses_sr1 = 1'b1;
        op_str: begin
            uses_sr1 = 1'b1;
            uses_sr2 = 1'b1;
        end
        default: uses_sr1 = 1'b0;
    endcase
end

// writeback itself is covered by the regfile write-through
assign id_ex_conflict = id_ex_valid && id_ex_load_reg &&
    ((uses_sr1 && sr1_idx == id_ex_dest) || (uses_sr2 && sr2_idx == id_ex_dest));
assign ex_mem_conflict = ex_mem_valid && ex_mem_load_reg &&
    ((uses_sr1 && sr1_idx == ex_mem_dest) || (uses_sr2 && sr2_idx == ex_mem_dest));

// fetch waits until the branch resolves in the memory stage
assign branch_in_flight = (if_id_valid && opcode == op_br) ||
    (id_ex_valid && id_ex_opcode == op_br) ||
    (ex_mem_valid && ex_mem_opcode == op_br);

assign id_hold = if_id_valid && (id_ex_conflict || ex_mem_conflict);
assign id_bubble = id_hold;
assign if_hold = branch_in_flight || id_hold;

endmodule : hazard_controller

//--- hw/cpu.sv
module cpu (
    input  logic                 clk,
    input  logic                 reset,
    output lc3b_types::lc3b_word imem_addr,
    input  lc3b_types::lc3b_word imem_rdata,
    output logic                 dmem_read,
    output logic                 dmem_write,
    output lc3b_types::lc3b_word dmem_addr,
    output lc3b_types::lc3b_word dmem_wdata,
    input  lc3b_types::lc3b_word dmem_rdata,
    output logic                 reg_load,
    output lc3b_types::lc3b_reg  reg_dest,
    output lc3b_types::lc3b_word reg_data
);

import lc3b_types::*;

// hazard and branch control
logic if_hold;
logic id_hold;
logic id_bubble;
logic br_taken;
lc3b_word br_target;

// IF/ID barrier
logic if_id_valid;
lc3b_word if_id_ir;
lc3b_word if_id_pc;

// ID/EX barrier
logic id_ex_valid;
lc3b_opcode id_ex_opcode;
lc3b_alu_op id_ex_alu_op;
lc3b_wb_sel id_ex_wb_sel;
logic id_ex_load_reg;
lc3b_reg id_ex_dest;
logic id_ex_sets_cc;
logic id_ex_mem_read;
logic id_ex_mem_write;
lc3b_word id_ex_sr1;
lc3b_word id_ex_sr2;
lc3b_word id_ex_imm;
lc3b_word id_ex_pc;
lc3b_nzp id_ex_nzp;

// EX/MEM barrier
logic ex_mem_valid;
lc3b_opcode ex_mem_opcode;
lc3b_wb_sel ex_mem_wb_sel;
logic ex_mem_load_reg;
lc3b_reg ex_mem_dest;
logic ex_mem_sets_cc;
logic ex_mem_mem_read;
logic ex_mem_mem_write;
lc3b_word ex_mem_alu;
lc3b_word ex_mem_store_data;
lc3b_nzp ex_mem_nzp;

hazard_controller hazard_controller_i (
    .if_id_valid,
    .if_id_ir,
    .id_ex_valid,
    .id_ex_opcode,
    .id_ex_load_reg,
    .id_ex_dest,
    .ex_mem_valid,
    .ex_mem_opcode,
    .ex_mem_load_reg,
    .ex_mem_dest,
    .if_hold,
    .id_hold,
    .id_bubble
);

stage_if stage_if_i (
    .clk,
    .reset,
    .if_hold,
    .br_taken,
    .br_target,
    .imem_addr,
    .imem_rdata,
    .if_id_valid,
    .if_id_ir,
    .if_id_pc
);

// the MEM/WB barrier doubles as the retire record on the top ports
stage_id stage_id_i (
    .clk,
    .reset,
    .id_hold,
    .id_bubble,
    .if_id_valid,
    .if_id_ir,
    .if_id_pc,
    .wb_load(reg_load),
    .wb_dest(reg_dest),
    .wb_data(reg_data),
    .id_ex_valid,
    .id_ex_opcode,
    .id_ex_alu_op,
    .id_ex_wb_sel,
    .id_ex_load_reg,
    .id_ex_dest,
    .id_ex_sets_cc,
    .id_ex_mem_read,
    .id_ex_mem_write,
    .id_ex_sr1,
    .id_ex_sr2,
    .id_ex_imm,
    .id_ex_pc,
    .id_ex_nzp
);

stage_ex stage_ex_i (
    .clk,
    .reset,
    .id_ex_valid,
    .id_ex_opcode,
    .id_ex_alu_op,
    .id_ex_wb_sel,
    .id_ex_load_reg,
    .id_ex_dest,
    .id_ex_sets_cc,
    .id_ex_mem_read,
    .id_ex_mem_write,
    .id_ex_sr1,
    .id_ex_sr2,
    .id_ex_imm,
    .id_ex_pc,
    .id_ex_nzp,
    .ex_mem_valid,
    .ex_mem_opcode,
    .ex_mem_wb_sel,
    .ex_mem_load_reg,
    .ex_mem_dest,
    .ex_mem_sets_cc,
    .ex_mem_mem_read,
    .ex_mem_mem_write,
    .ex_mem_alu,
    .ex_mem_store_data,
    .ex_mem_nzp
);

stage_mem stage_mem_i (
    .clk,
    .reset,
    .ex_mem_valid,
    .ex_mem_opcode,
    .ex_mem_wb_sel,
    .ex_mem_load_reg,
    .ex_mem_dest,
    .ex_mem_sets_cc,
    .ex_mem_mem_read,
    .ex_mem_mem_write,
    .ex_mem_alu,
    .ex_mem_store_data,
    .ex_mem_nzp,
    .dmem_read,
    .dmem_write,
    .dmem_addr,
    .dmem_wdata,
    .dmem_rdata,
    .br_taken,
    .br_target,
    .wb_load(reg_load),
    .wb_dest(reg_dest),
    .wb_data(reg_data)
);

endmodule : cpu

//--- sim/cpu_sva.sv
module cpu_sva (
    input logic                 clk,
    input logic                 reset,
    input lc3b_types::lc3b_word imem_addr,
    input logic                 dmem_read,
    input logic                 dmem_write
);

timeunit 1ns;
timeprecision 1ps;

// a data access is a load or a store, never both
strobes_exclusive: assert property (@(negedge clk) !(dmem_read && dmem_write))
    else $error("dmem_read and dmem_write are high together");

// the pipeline stays empty through reset and the cycle that follows
quiet_after_reset: assert property (
    @(negedge clk) (reset || $past(reset)) |-> !(dmem_read || dmem_write)
) else $error("data strobe active during reset or in the cycle after it");

// instruction words are aligned
fetch_aligned: assert property (@(negedge clk) imem_addr[0] == 1'b0)
    else $error("imem_addr is odd");

endmodule : cpu_sva

bind cpu cpu_sva cpu_sva_i (
    .clk(clk),
    .reset(reset),
    .imem_addr(imem_addr),
    .dmem_read(dmem_read),
    .dmem_write(dmem_write)
);

//--- sim/cpu_tb.sv
module cpu_tb;

timeunit 1ns;
timeprecision 1ps;

import lc3b_types::*;

localparam int mem_words = 2 ** mem_index_bits;
localparam int retire_target = 600;
localparam int wait_limit = 200;
localparam int model_step_limit = 10000;
localparam logic [31:0] seed = 32'hef68dcef;

logic clk;
logic reset;
lc3b_word imem_addr;
lc3b_word imem_rdata;
logic dmem_read;
logic dmem_write;
lc3b_word dmem_addr;
lc3b_word dmem_wdata;
lc3b_word dmem_rdata;
logic reg_load;
lc3b_reg reg_dest;
lc3b_word reg_data;

lc3b_word imem [mem_words];
lc3b_word dmem [mem_words];
lc3b_word dmem_init [mem_words];

// reference model state
lc3b_word ref_regs [reg_count];
lc3b_word ref_dmem [mem_words];
lc3b_word ref_pc;
lc3b_nzp ref_cc;
int taken_branches;

// expected events, oldest first
lc3b_reg exp_reg_dest [$];
lc3b_word exp_reg_data [$];
lc3b_word exp_store_addr [$];
lc3b_word exp_store_data [$];

logic [31:0] rng_state;
int retired;
int stores_seen;

cpu dut_i (
    .clk(clk),
    .reset(reset),
    .imem_addr(imem_addr),
    .imem_rdata(imem_rdata),
    .dmem_read(dmem_read),
    .dmem_write(dmem_write),
    .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_rdata(dmem_rdata),
    .reg_load(reg_load),
    .reg_dest(reg_dest),
    .reg_data(reg_data)
);

always #5 clk = ~clk;

// both memories wrap on address bits 8 to 1
assign imem_rdata = imem[imem_addr[mem_index_bits:1]];
assign dmem_rdata = dmem_read ? dmem[dmem_addr[mem_index_bits:1]] : 16'h0000;

// data memory reloads its initial image during reset
always @(posedge clk) begin
    if (reset) begin
        for (int i = 0; i < mem_words; i++) begin
            dmem[i] <= dmem_init[i];
        end
    end else if (dmem_write) begin
        dmem[dmem_addr[mem_index_bits:1]] <= dmem_wdata;
    end
end

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

function automatic lc3b_nzp flags_of(input lc3b_word value);
    if (value[15]) begin
        return 3'b100;
    end
    if (value == 16'h0000) begin
        return 3'b010;
    end
    return 3'b001;
endfunction

function automatic lc3b_word random_instruction();
    logic [31:0] pick;
    logic [31:0] fields;
    lc3b_word ir;
    pick = next_random();
    fields = next_random();
    ir = fields[15:0];
    case (pick[3:0])
        4'd0, 4'd1, 4'd2: ir[15:12] = op_add;
        4'd3, 4'd4: ir[15:12] = op_and;
        4'd5, 4'd6: begin
            ir[15:12] = op_not;
            ir[5:0] = 6'b111111;
        end
        4'd7, 4'd8, 4'd9: ir[15:12] = op_ldr;
        4'd10, 4'd11: ir[15:12] = op_str;
        4'd12, 4'd13: ir[15:12] = op_lea;
        default: begin
            // short forward hops, so the program never spins without retiring
            ir[15:12] = op_br;
            ir[8:0] = {5'b00000, fields[19:16]};
        end
    endcase
    if ((ir[15:12] == op_add || ir[15:12] == op_and) && !ir[5]) begin
        ir[4:3] = 2'b00;
    end
    // crowd half of the program into r0..r3 for denser dependencies
    if (pick[4] && ir[15:12] != op_br) begin
        ir[11] = 1'b0;
        ir[8] = 1'b0;
    end
    return ir;
endfunction

task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first failed check");
endtask

// executes one instruction of the ISA and queues what it should produce
task automatic step_model();
    lc3b_word ir;
    lc3b_word op_b;
    lc3b_word result;
    lc3b_word addr;
    lc3b_word pc_offset;
    logic writes;
    ir = imem[ref_pc[mem_index_bits:1]];
    ref_pc = ref_pc + 16'd2;
    op_b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : ref_regs[ir[2:0]];
    addr = ref_regs[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
    pc_offset = {{6{ir[8]}}, ir[8:0], 1'b0};
    result = 16'h0000;
    writes = 1'b1;
    case (ir[15:12])
        op_add: result = ref_regs[ir[8:6]] + op_b;
        op_and: result = ref_regs[ir[8:6]] & op_b;
        op_not: result = ~ref_regs[ir[8:6]];
        op_ldr: result = ref_dmem[addr[mem_index_bits:1]];
        op_lea: result = ref_pc + pc_offset;
        op_str: begin
            writes = 1'b0;
            ref_dmem[addr[mem_index_bits:1]] = ref_regs[ir[11:9]];
            exp_store_addr.push_back(addr);
            exp_store_data.push_back(ref_regs[ir[11:9]]);
        end
        op_br: begin
            writes = 1'b0;
            if ((ir[11:9] & ref_cc) != 3'b000) begin
                ref_pc = ref_pc + pc_offset;
                taken_branches++;
            end
        end
        default: writes = 1'b0;
    endcase
    if (writes) begin
        ref_regs[ir[11:9]] = result;
        exp_reg_dest.push_back(ir[11:9]);
        exp_reg_data.push_back(result);
        // LEA leaves the flags alone
        if (ir[15:12] != op_lea) begin
            ref_cc = flags_of(result);
        end
    end
endtask

task automatic run_model_until(input logic want_store);
    int steps;
    steps = 0;
    while ((want_store ? exp_store_addr.size() : exp_reg_dest.size()) == 0) begin
        step_model();
        steps++;
        if (steps > model_step_limit) begin
            fail_run("the reference model ran out of expected events");
        end
    end
endtask

task automatic wait_for_event();
    int cycles;
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
        if (cycles > wait_limit) begin
            fail_run($sformatf("no register write or store for %0d cycles", wait_limit));
        end
    end while (!(reg_load || dmem_write));
endtask

task automatic check_reset_state();
    assert (imem_addr == 16'h0000) else
        fail_run($sformatf("mismatch at %0t: imem_addr expected %h, got %h",
            $time, 16'h0000, imem_addr));
    assert (!reg_load) else
        fail_run($sformatf("mismatch at %0t: reg_load expected 0, got %b", $time, reg_load));
    assert (!(dmem_read || dmem_write)) else
        fail_run("a data strobe was active right after reset");
endtask

task automatic check_store();
    lc3b_word want_addr;
    lc3b_word want_data;
    run_model_until(1'b1);
    want_addr = exp_store_addr.pop_front();
    want_data = exp_store_data.pop_front();
    assert (dmem_addr == want_addr) else
        fail_run($sformatf("mismatch at %0t: dmem_addr expected %h, got %h",
            $time, want_addr, dmem_addr));
    assert (dmem_wdata == want_data) else
        fail_run($sformatf("mismatch at %0t: dmem_wdata expected %h, got %h",
            $time, want_data, dmem_wdata));
    stores_seen++;
endtask

task automatic check_retire();
    lc3b_reg want_dest;
    lc3b_word want_data;
    run_model_until(1'b0);
    want_dest = exp_reg_dest.pop_front();
    want_data = exp_reg_data.pop_front();
    assert (reg_dest == want_dest) else
        fail_run($sformatf("mismatch at %0t: reg_dest expected %0d, got %0d",
            $time, want_dest, reg_dest));
    assert (reg_data == want_data) else
        fail_run($sformatf("mismatch at %0t: reg_data expected %h, got %h",
            $time, want_data, reg_data));
    retired++;
endtask

initial begin
    logic [31:0] r;
    clk = 1'b0;
    reset = 1'b1;
    rng_state = seed;
    retired = 0;
    stores_seen = 0;
    taken_branches = 0;
    for (int i = 0; i < mem_words; i++) begin
        r = next_random();
        dmem_init[i] = r[15:0];
        ref_dmem[i] = r[15:0];
    end
    for (int i = 0; i < mem_words; i++) begin
        imem[i] = random_instruction();
    end
    for (int i = 0; i < reg_count; i++) begin
        ref_regs[i] = 16'h0000;
    end
    ref_pc = 16'h0000;
    // flags start out holding z
    ref_cc = 3'b010;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_reset_state();
    while (retired < retire_target) begin
        wait_for_event();
        if (dmem_write) begin
            check_store();
        end
        if (reg_load) begin
            check_retire();
        end
    end
    if (stores_seen > 0 && taken_branches > 0) begin
        $display("ALL CHECKS PASSED");
        $finish;
    end else begin
        fail_run("the random program never stored or never took a branch");
    end
end

endmodule : cpu_tb

//--- vlog.f
hw/lc3b_types.sv
hw/stage_if.sv
hw/stage_id.sv
hw/stage_ex.sv
hw/stage_mem.sv
hw/hazard_controller.sv
hw/cpu.sv
sim/cpu_sva.sv
sim/cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the cpu testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cpu_tb -Mdir obj_dir -o cpu_tb_sim -f vlog.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/cpu_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
